/* rtl/vec_pkg.sv */
// Vector coprocessor shared definitions
// Sizes, opcodes, the host instruction word and the structs
// passed between dispatcher, sequencer, lanes and response unit

package vec_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEM_W         = 32;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned VLEN_ELEMS     = 16;
  localparam int unsigned ELEMS_PER_LANE = VLEN_ELEMS / NR_LANES;

  localparam int unsigned VREG_IDX_W = $clog2(NR_VREGS);
  localparam int unsigned ELEM_IDX_W = $clog2(VLEN_ELEMS);
  localparam int unsigned ROW_IDX_W  = $clog2(ELEMS_PER_LANE);
  localparam int unsigned LANE_IDX_W = $clog2(NR_LANES);

  // Instruction word layout
  localparam int unsigned OP_W      = 3;
  localparam int unsigned INSN_W    = 48;
  localparam int unsigned VV_PAD_W  = INSN_W - OP_W - 3 * VREG_IDX_W;
  localparam int unsigned VX_PAD_W  = INSN_W - OP_W - VREG_IDX_W - ELEM_IDX_W - ELEM_W;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  typedef enum logic [OP_W-1:0] {
    OP_BCAST = 3'd0,
    OP_WRITE = 3'd1,
    OP_ADD   = 3'd2,
    OP_SUB   = 3'd3,
    OP_AND   = 3'd4,
    OP_XOR   = 3'd5,
    OP_READ  = 3'd6
  } vec_op_e;

  //////////////////////////////////////////////////
  // Host instruction word
  //////////////////////////////////////////////////

  // Register-register form, used by the ALU ops
  typedef struct packed {
    vec_op_e                op;
    logic [VREG_IDX_W-1:0]  vd;
    logic [VREG_IDX_W-1:0]  vs1;
    logic [VREG_IDX_W-1:0]  vs2;
    logic [VV_PAD_W-1:0]    pad;
  } vv_insn_t;

  // Register-scalar form, used by broadcast, write and read
  typedef struct packed {
    vec_op_e                op;
    logic [VREG_IDX_W-1:0]  vreg;
    logic [ELEM_IDX_W-1:0]  elem;
    logic [VX_PAD_W-1:0]    pad;
    logic [ELEM_W-1:0]      scalar;
  } vx_insn_t;

  // Opcode sits in the top bits of both views
  typedef union packed {
    vv_insn_t vv;
    vx_insn_t vx;
  } vec_insn_u;

  //////////////////////////////////////////////////
  // Internal structs
  //////////////////////////////////////////////////

  // Decoded instruction, dispatcher to sequencer
  typedef struct packed {
    vec_op_e                op;
    logic [VREG_IDX_W-1:0]  vd;
    logic [VREG_IDX_W-1:0]  vs1;
    logic [VREG_IDX_W-1:0]  vs2;
    logic [ELEM_IDX_W-1:0]  elem;
    logic [ELEM_W-1:0]      scalar;
  } vec_req_t;

  // One row command, broadcast to every lane
  typedef struct packed {
    logic                   valid;
    vec_op_e                op;
    logic [VREG_IDX_W-1:0]  vd;
    logic [VREG_IDX_W-1:0]  vs1;
    logic [VREG_IDX_W-1:0]  vs2;
    logic [ROW_IDX_W-1:0]   row;
    logic [LANE_IDX_W-1:0]  lane;
    logic [ELEM_W-1:0]      scalar;
  } lane_cmd_t;

  typedef struct packed {
    logic [ELEM_W-1:0]      data;
    vec_op_e                op;
  } vec_resp_t;

endpackage : vec_pkg

/* rtl/vec_dispatcher.sv */
// Vector coprocessor dispatcher
// Accepts host instruction words, decodes the two instruction
// forms into a request and starts the sequencer. Only one
// instruction is in flight, so ready stays low until its
// response has been taken by the host.

module vec_dispatcher (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Host request channel
  input  vec_pkg::vec_insn_u   acc_req_i,
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  // Sequencer side
  output vec_pkg::vec_req_t    req_o,
  output logic                 start_o,
  input  logic                 finished_i,
  // Response unit side
  input  logic                 resp_busy_i
);

  import vec_pkg::*;

  logic     in_progress_q;
  logic     accept;
  vec_req_t req_d;
  vec_req_t req_q;

  // Idle and no response waiting for the host
  assign acc_req_ready_o = !in_progress_q && !resp_busy_i;
  assign accept          = acc_req_valid_i && acc_req_ready_o;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    req_d    = '0;
    req_d.op = acc_req_i.vv.op;
    case (acc_req_i.vv.op)
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        req_d.vd  = acc_req_i.vv.vd;
        req_d.vs1 = acc_req_i.vv.vs1;
        req_d.vs2 = acc_req_i.vv.vs2;
      end
      default: begin
        // Scalar form: one register is both source and destination
        req_d.vd     = acc_req_i.vx.vreg;
        req_d.vs1    = acc_req_i.vx.vreg;
        req_d.elem   = acc_req_i.vx.elem;
        req_d.scalar = acc_req_i.vx.scalar;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_progress_q <= 1'b0;
      start_o       <= 1'b0;
    end else begin
      start_o <= accept;
      if (accept) begin
        in_progress_q <= 1'b1;
      end else if (finished_i) begin
        in_progress_q <= 1'b0;
      end
    end
  end

  // Request held until the next accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_d;
    end
  end

  assign req_o = req_q;

endmodule : vec_dispatcher

/* rtl/vec_sequencer.sv */
// Vector coprocessor sequencer
// Walks one instruction over the lane rows, one row per cycle,
// and pulses finished once lane 0 has written the last row

module vec_sequencer (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  vec_pkg::vec_req_t    req_i,
  input  logic                 start_i,
  input  logic                 row_done_i,
  output vec_pkg::lane_cmd_t   cmd_o,
  output logic                 finished_o
);

  import vec_pkg::*;

  logic                  active_q;
  logic                  wait_q;
  logic [ROW_IDX_W-1:0]  row_q;
  logic [ROW_IDX_W-1:0]  last_row_q;
  logic [LANE_IDX_W-1:0] tgt_lane;
  logic [ROW_IDX_W-1:0]  tgt_row;
  logic                  single_row;

  // Element e sits in lane e mod NR_LANES, row e div NR_LANES
  assign tgt_lane   = req_i.elem[LANE_IDX_W-1:0];
  assign tgt_row    = req_i.elem[ELEM_IDX_W-1:LANE_IDX_W];
  assign single_row = (req_i.op == OP_WRITE) || (req_i.op == OP_READ);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q   <= 1'b0;
      wait_q     <= 1'b0;
      finished_o <= 1'b0;
    end else begin
      finished_o <= wait_q && row_done_i;
      if (wait_q && row_done_i) begin
        wait_q <= 1'b0;
      end
      if (start_i) begin
        active_q <= 1'b1;
      end else if (active_q && (row_q == last_row_q)) begin
        // Last row issued, now wait for it to leave the lanes
        active_q <= 1'b0;
        wait_q   <= 1'b1;
      end
    end
  end

  // Row counter
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      row_q      <= single_row ? tgt_row : '0;
      last_row_q <= single_row ? tgt_row : ROW_IDX_W'(ELEMS_PER_LANE - 1);
    end else if (active_q) begin
      row_q <= row_q + 1'b1;
    end
  end

  always_comb begin
    cmd_o.valid  = active_q;
    cmd_o.op     = req_i.op;
    cmd_o.vd     = req_i.vd;
    cmd_o.vs1    = req_i.vs1;
    cmd_o.vs2    = req_i.vs2;
    cmd_o.row    = row_q;
    cmd_o.lane   = tgt_lane;
    cmd_o.scalar = req_i.scalar;
  end

endmodule : vec_sequencer

/* rtl/vec_lane.sv */
// Vector coprocessor lane
// Holds one slice of the vector register file and an integer
// ALU. Two stages: operand read, then compute and write back.
// Consecutive rows overlap, one in each stage.

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  vec_pkg::lane_cmd_t         cmd_i,
  output logic [vec_pkg::ELEM_W-1:0] rd_data_o,
  output logic                       row_done_o
);

  import vec_pkg::*;

  // Register file slice, indexed by register then row
  logic [ELEM_W-1:0] vrf_q [NR_VREGS][ELEMS_PER_LANE];

  lane_cmd_t         s1_cmd_q;
  logic [ELEM_W-1:0] op_a_q;
  logic [ELEM_W-1:0] op_b_q;
  logic [ELEM_W-1:0] result;
  logic              wr_en;

  //////////////////////////////////////////////////
  // Read stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_cmd_q <= '0;
    end else begin
      s1_cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_i.valid) begin
      op_a_q <= vrf_q[cmd_i.vs1][cmd_i.row];
      op_b_q <= vrf_q[cmd_i.vs2][cmd_i.row];
    end
  end

  //////////////////////////////////////////////////
  // ALU and write stage
  //////////////////////////////////////////////////

  always_comb begin
    result = op_a_q;
    wr_en  = 1'b0;
    case (s1_cmd_q.op)
      OP_BCAST: begin
        result = s1_cmd_q.scalar;
        wr_en  = 1'b1;
      end
      OP_WRITE: begin
        // Only the lane owning the element
        result = s1_cmd_q.scalar;
        wr_en  = (s1_cmd_q.lane == LANE_IDX_W'(LANE_ID));
      end
      OP_ADD: begin
        result = op_a_q + op_b_q;
        wr_en  = 1'b1;
      end
      OP_SUB: begin
        result = op_a_q - op_b_q;
        wr_en  = 1'b1;
      end
      OP_AND: begin
        result = op_a_q & op_b_q;
        wr_en  = 1'b1;
      end
      OP_XOR: begin
        result = op_a_q ^ op_b_q;
        wr_en  = 1'b1;
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s1_cmd_q.valid && wr_en) begin
      vrf_q[s1_cmd_q.vd][s1_cmd_q.row] <= result;
    end
  end

  // Read data stays until the next read
  always_ff @(posedge clk_i) begin
    if (s1_cmd_q.valid && (s1_cmd_q.op == OP_READ)) begin
      rd_data_o <= op_a_q;
    end
  end

  assign row_done_o = s1_cmd_q.valid;

endmodule : vec_lane

/* rtl/vec_resp_unit.sv */
// Vector coprocessor response unit
// Builds one response per finished instruction and holds it
// stable until the host takes it

module vec_resp_unit (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            finished_i,
  input  vec_pkg::vec_op_e                                op_i,
  input  logic [vec_pkg::LANE_IDX_W-1:0]                  lane_sel_i,
  input  logic [vec_pkg::NR_LANES-1:0][vec_pkg::ELEM_W-1:0] lane_data_i,
  input  logic                                            acc_resp_ready_i,
  output vec_pkg::vec_resp_t                              acc_resp_o,
  output logic                                            acc_resp_valid_o,
  output logic                                            busy_o
);

  import vec_pkg::*;

  logic      pending_q;
  vec_resp_t resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (finished_i) begin
      pending_q <= 1'b1;
    end else if (pending_q && acc_resp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // Response word, loaded only when an instruction finishes
  always_ff @(posedge clk_i) begin
    if (finished_i) begin
      resp_q.op   <= op_i;
      resp_q.data <= (op_i == OP_READ) ? lane_data_i[lane_sel_i] : '0;
    end
  end

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = pending_q;
  assign busy_o           = pending_q;

endmodule : vec_resp_unit

/* rtl/vec_top.sv */
// Vector coprocessor top level
// Host request and response channels around the dispatcher,
// the row sequencer, NR_LANES lanes and the response unit

module vec_top (
  input  logic                clk_i,
  input  logic                reset_i,
  // Request channel
  input  vec_pkg::vec_insn_u  acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  // Response channel
  output vec_pkg::vec_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i
);

  import vec_pkg::*;

  vec_req_t                          req;
  logic                              start;
  logic                              finished;
  logic                              resp_busy;
  lane_cmd_t                         cmd;
  logic [NR_LANES-1:0]               row_done;
  logic [NR_LANES-1:0][ELEM_W-1:0]   lane_data;

  //////////////////////////////////////////////////
  // Dispatcher and sequencer
  //////////////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i          ),
    .reset_i         (reset_i        ),
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .req_o           (req            ),
    .start_o         (start          ),
    .finished_i      (finished       ),
    .resp_busy_i     (resp_busy      )
  );

  // Completion is tracked on lane 0
  vec_sequencer i_sequencer (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (req        ),
    .start_i    (start      ),
    .row_done_i (row_done[0]),
    .cmd_o      (cmd        ),
    .finished_o (finished   )
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar lane = 0; lane < NR_LANES; lane++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (lane)
    ) i_lane (
      .clk_i      (clk_i          ),
      .reset_i    (reset_i        ),
      .cmd_i      (cmd            ),
      .rd_data_o  (lane_data[lane]),
      .row_done_o (row_done[lane] )
    );
  end : gen_lanes

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  vec_resp_unit i_resp (
    .clk_i            (clk_i                      ),
    .reset_i          (reset_i                    ),
    .finished_i       (finished                   ),
    .op_i             (req.op                     ),
    .lane_sel_i       (req.elem[LANE_IDX_W-1:0]   ),
    .lane_data_i      (lane_data                  ),
    .acc_resp_ready_i (acc_resp_ready_i           ),
    .acc_resp_o       (acc_resp_o                 ),
    .acc_resp_valid_o (acc_resp_valid_o           ),
    .busy_o           (resp_busy                  )
  );

endmodule : vec_top

/* verif/vec_checker.sv */
// Vector coprocessor protocol checker
// Assertions on the host response channel and on request
// gating while a response waits, bound into vec_top

module vec_checker (
  input logic               clk_i,
  input logic               reset_i,
  input logic               acc_req_ready_o,
  input vec_pkg::vec_resp_t acc_resp_o,
  input logic               acc_resp_valid_o,
  input logic               acc_resp_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import vec_pkg::*;

  // Response channel empty out of reset
  resp_idle_after_reset: assert property (
    @(posedge clk_i) reset_i |=> !acc_resp_valid_o
  ) else $error("response valid high in the cycle after reset");

  // Response stable under back-pressure
  resp_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o)
  ) else $error("response dropped or changed before the host took it");

  // Nothing enters while a response waits
  no_req_while_pending: assert property (
    @(posedge clk_i) disable iff (reset_i)
    acc_resp_valid_o |-> !acc_req_ready_o
  ) else $error("request ready high while a response is pending");

endmodule : vec_checker

bind vec_top vec_checker i_vec_checker (
  .clk_i            (clk_i           ),
  .reset_i          (reset_i         ),
  .acc_req_ready_o  (acc_req_ready_o ),
  .acc_resp_o       (acc_resp_o      ),
  .acc_resp_valid_o (acc_resp_valid_o),
  .acc_resp_ready_i (acc_resp_ready_i)
);

/* verif/vec_tb.sv */
// Vector coprocessor testbench
// Builds a table of instruction words with expected responses
// from a shadow copy of the vector registers. It applies the
// table over the request channel and checks each response,
// with random back-pressure on the response channel.

module vec_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vec_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 200;

  typedef struct {
    string       name;
    vec_insn_u   insn;
    vec_resp_t   exp;
    int unsigned hold;
  } test_t;

  logic       clk_i = 1'b0;
  logic       reset_i;
  vec_insn_u  acc_req_i;
  logic       acc_req_valid_i;
  logic       acc_req_ready_o;
  vec_resp_t  acc_resp_o;
  logic       acc_resp_valid_o;
  logic       acc_resp_ready_i;

  test_t             tests[$];
  // Expected register contents, indexed by register and element
  logic [ELEM_W-1:0] shadow [NR_VREGS][VLEN_ELEMS];

  always #5 clk_i = ~clk_i;

  vec_top i_vec_top (
    .clk_i            (clk_i           ),
    .reset_i          (reset_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input string name, input vec_resp_t exp, input vec_resp_t act);
    if (act !== exp) begin
      $display("** Error: %s expected data=%h op=%0d actual data=%h op=%0d",
               name, exp.data, exp.op, act.data, act.op);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    abort_run();
  endtask

  //////////////////////////////////////////////////
  // Instruction words and reference model
  //////////////////////////////////////////////////

  function automatic vec_insn_u make_vx(vec_op_e op, int vreg, int elem, logic [ELEM_W-1:0] s);
    vec_insn_u w;
    w           = '0;
    w.vx.op     = op;
    w.vx.vreg   = vreg[VREG_IDX_W-1:0];
    w.vx.elem   = elem[ELEM_IDX_W-1:0];
    w.vx.scalar = s;
    return w;
  endfunction

  function automatic vec_insn_u make_vv(vec_op_e op, int vd, int vs1, int vs2);
    vec_insn_u w;
    w        = '0;
    w.vv.op  = op;
    w.vv.vd  = vd[VREG_IDX_W-1:0];
    w.vv.vs1 = vs1[VREG_IDX_W-1:0];
    w.vv.vs2 = vs2[VREG_IDX_W-1:0];
    return w;
  endfunction

  // Element-wise op definitions, subtraction wraps mod 2^32
  function automatic logic [ELEM_W-1:0] alu_ref(vec_op_e op, logic [ELEM_W-1:0] a,
                                                logic [ELEM_W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic int unsigned rand_hold();
    return $urandom_range(6, 0);
  endfunction

  task automatic push_test(string name, vec_insn_u insn, vec_resp_t exp, int unsigned hold);
    test_t t;
    t.name = name;
    t.insn = insn;
    t.exp  = exp;
    t.hold = hold;
    tests.push_back(t);
  endtask

  task automatic add_bcast(int vreg, logic [ELEM_W-1:0] s, int unsigned hold);
    vec_resp_t exp;
    exp = '{data: '0, op: OP_BCAST};
    for (int e = 0; e < VLEN_ELEMS; e++) begin
      shadow[vreg][e] = s;
    end
    push_test($sformatf("bcast v%0d", vreg), make_vx(OP_BCAST, vreg, 0, s), exp, hold);
  endtask

  task automatic add_write(int vreg, int elem, logic [ELEM_W-1:0] s, int unsigned hold);
    vec_resp_t exp;
    exp = '{data: '0, op: OP_WRITE};
    shadow[vreg][elem] = s;
    push_test($sformatf("write v%0d[%0d]", vreg, elem), make_vx(OP_WRITE, vreg, elem, s),
              exp, hold);
  endtask

  task automatic add_vv(vec_op_e op, int vd, int vs1, int vs2, int unsigned hold);
    vec_resp_t exp;
    exp = '{data: '0, op: op};
    for (int e = 0; e < VLEN_ELEMS; e++) begin
      shadow[vd][e] = alu_ref(op, shadow[vs1][e], shadow[vs2][e]);
    end
    push_test($sformatf("%s v%0d v%0d v%0d", op.name(), vd, vs1, vs2),
              make_vv(op, vd, vs1, vs2), exp, hold);
  endtask

  // Lane of element e is e mod NR_LANES, named for debug
  task automatic add_read(int vreg, int elem, int unsigned hold);
    vec_resp_t exp;
    exp = '{data: shadow[vreg][elem], op: OP_READ};
    push_test($sformatf("read v%0d[%0d] lane %0d", vreg, elem, elem % NR_LANES),
              make_vx(OP_READ, vreg, elem, '0), exp, hold);
  endtask

  task automatic build_table();
    // Fixed part: broadcast, then single element writes
    add_bcast(0, 32'hA5A5_0F0F, 0);
    for (int e = 0; e < VLEN_ELEMS; e += 3) begin
      add_read(0, e, (e / 3) % 4);
    end
    for (int e = 0; e < VLEN_ELEMS; e++) begin
      add_write(3, e, 32'hC0DE_0000 + 32'(e * 257), 1);
    end
    for (int k = 0; k < VLEN_ELEMS; k++) begin
      add_read(3, (k * 7) % VLEN_ELEMS, k % 4);
    end
    // Random part
    add_bcast(1, $urandom(), rand_hold());
    add_bcast(2, $urandom(), rand_hold());
    for (int e = 0; e < VLEN_ELEMS; e++) begin
      if ($urandom_range(1, 0) == 1) begin
        add_write(1, e, $urandom(), rand_hold());
      end
      if ($urandom_range(1, 0) == 1) begin
        add_write(2, e, $urandom(), rand_hold());
      end
    end
    // Forces a wrapping subtraction in element 0
    add_write(1, 0, 32'h0000_0001, 0);
    add_write(2, 0, 32'h0000_0002, 0);
    add_vv(OP_ADD, 4, 1, 2, rand_hold());
    add_vv(OP_SUB, 5, 1, 2, rand_hold());
    add_vv(OP_AND, 6, 1, 2, rand_hold());
    add_vv(OP_XOR, 7, 1, 2, rand_hold());
    for (int vd = 4; vd < NR_VREGS; vd++) begin
      for (int e = 0; e < VLEN_ELEMS; e++) begin
        add_read(vd, e, rand_hold());
      end
    end
    // Destination equal to a source
    add_vv(OP_XOR, 1, 1, 3, rand_hold());
    for (int e = 0; e < NR_LANES; e++) begin
      add_read(1, e * 5, rand_hold());
    end
  endtask

  //////////////////////////////////////////////////
  // Handshake waits and application
  //////////////////////////////////////////////////

  task automatic wait_req_ready();
    int unsigned cycles;
    cycles = 0;
    while (!acc_req_ready_o) begin
      if (cycles == TIMEOUT_CYCLES) report_timeout("acc_req_ready_o");
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_resp_valid();
    int unsigned cycles;
    cycles = 0;
    while (!acc_resp_valid_o) begin
      if (cycles == TIMEOUT_CYCLES) report_timeout("acc_resp_valid_o");
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  task automatic apply_test(input test_t t);
    acc_req_i       = t.insn;
    acc_req_valid_i = 1'b1;
    wait_req_ready();
    @(posedge clk_i);
    #1;
    acc_req_valid_i = 1'b0;
    acc_req_i       = '0;
    check_bit({t.name, " ready low in flight"}, 1'b0, acc_req_ready_o);
    wait_resp_valid();
    check_resp(t.name, t.exp, acc_resp_o);
    // Decoy request offered while the response waits
    acc_req_i       = make_vx(OP_BCAST, 0, 0, 32'hDEAD_BEEF);
    acc_req_valid_i = 1'b1;
    for (int unsigned h = 0; h < t.hold; h++) begin
      @(posedge clk_i);
      #1;
      check_bit({t.name, " valid held"}, 1'b1, acc_resp_valid_o);
      check_resp({t.name, " response held"}, t.exp, acc_resp_o);
      check_bit({t.name, " ready low while pending"}, 1'b0, acc_req_ready_o);
    end
    acc_resp_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    acc_resp_ready_i = 1'b0;
    acc_req_valid_i  = 1'b0;
    acc_req_i        = '0;
    check_bit({t.name, " valid low after take"}, 1'b0, acc_resp_valid_o);
    check_bit({t.name, " ready high after take"}, 1'b1, acc_req_ready_o);
  endtask

  initial begin
    reset_i          = 1'b1;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    void'($urandom(72));
    build_table();
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bit("valid low after reset", 1'b0, acc_resp_valid_o);
    check_bit("ready high after reset", 1'b1, acc_req_ready_o);
    foreach (tests[i]) begin
      apply_test(tests[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule : vec_tb

/* all.f */
rtl/vec_pkg.sv
rtl/vec_dispatcher.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_resp_unit.sv
rtl/vec_top.sv
verif/vec_checker.sv
verif/vec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the vector coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vec_tb -f all.f

./obj_dir/Vvec_tb | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
